//--- hw/core_pkg.sv
// rv64i core package
`default_nettype none

package core_pkg;

  typedef logic [63:0] xlen_t;

  localparam xlen_t PC_START = 64'h0000_0000_8000_0000;

  localparam logic [6:0] OP_IMM    = 7'h13;
  localparam logic [6:0] OP_REG    = 7'h33;
  localparam logic [6:0] OP_LOAD   = 7'h03;
  localparam logic [6:0] OP_STORE  = 7'h23;
  localparam logic [6:0] OP_BRANCH = 7'h63;
  localparam logic [6:0] OP_JAL    = 7'h6f;
  localparam logic [6:0] OP_TRAP   = 7'h6b;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // same 32-bit word, seen through either field layout
  typedef union packed {
    logic [31:0] word;
    r_fmt_t      r;
    i_fmt_t      i;
  } inst_t;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    PASS_B
  } alu_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    xlen_t      op1;
    xlen_t      op2;
    logic       branch;
    logic       jal;
    xlen_t      pc;
    xlen_t      imm;
    logic       rd_wen;
    logic [4:0] rd_addr;
    logic       mem_ren;
    logic       mem_wen;
    xlen_t      store_data;
  } id_ex_t;

  typedef struct packed {
    xlen_t result;
    logic  pc_jmp;
    xlen_t pc_jmpaddr;
  } ex_out_t;

  typedef struct packed {
    logic        valid;
    xlen_t       pc;
    logic [31:0] inst;
    logic        wen;
    logic [7:0]  wdest;
    xlen_t       wdata;
  } commit_t;

endpackage

`default_nettype wire

//--- hw/if_stage.sv
// instruction fetch
`default_nettype none

module if_stage import core_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          halt_i,
  input  logic                          pc_jmp_i,
  input  xlen_t                         pc_jmpaddr_i,
  input  logic                          prog_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr_i,
  input  logic [31:0]                   prog_data_i,
  output xlen_t                         pc_o,
  output inst_t                         inst_o
);

  localparam int IDX_W = $clog2(IMEM_DEPTH);

  logic [31:0] imem [IMEM_DEPTH];

  // program load port
  always_ff @(posedge clock) begin
    if (prog_we_i) begin
      imem[prog_addr_i] <= prog_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_o <= PC_START;
    end else if (!halt_i) begin
      pc_o <= pc_jmp_i ? pc_jmpaddr_i : pc_o + 64'd4;
    end
  end

  // word index of the pc, base address bits dropped
  assign inst_o.word = imem[pc_o[IDX_W+1:2]];

endmodule

`default_nettype wire

//--- hw/id_stage.sv
// instruction decode
`default_nettype none

module id_stage import core_pkg::*; (
  input  inst_t      inst_i,
  input  xlen_t      pc_i,
  input  logic       halt_i,
  input  xlen_t      rs1_data_i,
  input  xlen_t      rs2_data_i,
  input  xlen_t      mem_rdata_i,
  output logic [4:0] rs1_addr_o,
  output logic [4:0] rs2_addr_o,
  output logic       mem_ren_o,
  output logic       mem_wen_o,
  output xlen_t      mem_addr_o,
  output xlen_t      mem_wdata_o,
  output id_ex_t     ex_o,
  input  xlen_t      ex_result_i,
  output logic       rd_wen_o,
  output logic [4:0] rd_addr_o,
  output xlen_t      rd_data_o,
  output logic       is_trap_o
);

  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_j;
  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode     = inst_i.r.opcode;
  assign funct3     = inst_i.r.funct3;
  assign rs1_addr_o = inst_i.r.rs1;
  assign rs2_addr_o = inst_i.r.rs2;

  assign imm_i = {{52{inst_i.i.imm12[11]}}, inst_i.i.imm12};
  assign imm_s = {{52{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rd};
  assign imm_b = {{52{inst_i.r.funct7[6]}}, inst_i.r.rd[0], inst_i.r.funct7[5:0],
                  inst_i.r.rd[4:1], 1'b0};
  // j-type bits 19:12 sit where rs1 and funct3 live in the i view
  assign imm_j = {{44{inst_i.i.imm12[11]}}, inst_i.i.rs1, inst_i.i.funct3,
                  inst_i.i.imm12[0], inst_i.i.imm12[10:1], 1'b0};

  always_comb begin
    ex_o            = '0;
    ex_o.alu_op     = PASS_B;
    ex_o.pc         = pc_i;
    ex_o.op1        = rs1_data_i;
    ex_o.op2        = rs2_data_i;
    ex_o.imm        = imm_i;
    ex_o.store_data = rs2_data_i;
    ex_o.rd_addr    = inst_i.r.rd;
    case (opcode)
      OP_IMM: begin
        ex_o.op2    = imm_i;
        ex_o.alu_op = ADD;
        ex_o.rd_wen = 1'b1;
      end
      OP_REG: begin
        ex_o.rd_wen = 1'b1;
        case (funct3)
          3'b000:  ex_o.alu_op = inst_i.r.funct7[5] ? SUB : ADD;
          3'b100:  ex_o.alu_op = XOR;
          3'b110:  ex_o.alu_op = OR;
          3'b111:  ex_o.alu_op = AND;
          default: ex_o.rd_wen = 1'b0;
        endcase
      end
      OP_LOAD: begin
        ex_o.op2     = imm_i;
        ex_o.alu_op  = ADD;
        ex_o.mem_ren = 1'b1;
        ex_o.rd_wen  = 1'b1;
      end
      OP_STORE: begin
        ex_o.imm     = imm_s;
        ex_o.op2     = imm_s;
        ex_o.alu_op  = ADD;
        ex_o.mem_wen = !halt_i;
      end
      OP_BRANCH: begin
        ex_o.imm    = imm_b;
        // bne only
        ex_o.branch = (funct3 == 3'b001);
      end
      OP_JAL: begin
        ex_o.imm    = imm_j;
        ex_o.jal    = 1'b1;
        ex_o.rd_wen = 1'b1;
      end
      default: ;
    endcase
    if (ex_o.rd_addr == 5'd0 || halt_i) begin
      ex_o.rd_wen = 1'b0;
    end
  end

  // load/store address comes back from the alu
  assign mem_addr_o  = ex_result_i;
  assign mem_wdata_o = ex_o.store_data;
  assign mem_ren_o   = ex_o.mem_ren;
  assign mem_wen_o   = ex_o.mem_wen;

  assign rd_wen_o  = ex_o.rd_wen;
  assign rd_addr_o = ex_o.rd_addr;
  assign rd_data_o = ex_o.jal     ? pc_i + 64'd4 :
                     ex_o.mem_ren ? mem_rdata_i  : ex_result_i;

  assign is_trap_o = (opcode == OP_TRAP);

endmodule

`default_nettype wire

//--- hw/exe_stage.sv
// execute stage
`default_nettype none

module exe_stage import core_pkg::*; (
  input  id_ex_t  ex_i,
  output ex_out_t out_o
);

  logic taken;

  always_comb begin
    case (ex_i.alu_op)
      ADD:     out_o.result = ex_i.op1 + ex_i.op2;
      SUB:     out_o.result = ex_i.op1 - ex_i.op2;
      AND:     out_o.result = ex_i.op1 & ex_i.op2;
      OR:      out_o.result = ex_i.op1 | ex_i.op2;
      XOR:     out_o.result = ex_i.op1 ^ ex_i.op2;
      default: out_o.result = ex_i.op2;
    endcase
  end

  // bne taken when the two source registers differ
  assign taken = ex_i.branch && (ex_i.op1 != ex_i.op2);

  assign out_o.pc_jmp     = taken || ex_i.jal;
  assign out_o.pc_jmpaddr = ex_i.pc + ex_i.imm;

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
// data memory
`default_nettype none

module mem_stage import core_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic  clock,
  input  logic  ren_i,
  input  logic  wen_i,
  input  xlen_t addr_i,
  input  xlen_t wdata_i,
  output xlen_t rdata_o
);

  localparam int IDX_W = $clog2(DMEM_DEPTH);

  xlen_t                dmem [DMEM_DEPTH];
  logic [IDX_W-1:0]     idx;

  // 64-bit words, byte offset ignored
  assign idx = addr_i[IDX_W+2:3];

  always_ff @(posedge clock) begin
    if (wen_i) begin
      dmem[idx] <= wdata_i;
    end
  end

  assign rdata_o = ren_i ? dmem[idx] : '0;

endmodule

`default_nettype wire

//--- hw/regfile.sv
// integer register file
`default_nettype none

module regfile import core_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       w_ena_i,
  input  logic [4:0] w_addr_i,
  input  xlen_t      w_data_i,
  input  logic [4:0] r_addr1_i,
  input  logic [4:0] r_addr2_i,
  output xlen_t      r_data1_o,
  output xlen_t      r_data2_o,
  output xlen_t      a0_o
);

  xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_ena_i && w_addr_i != 5'd0) begin
      regs[w_addr_i] <= w_data_i;
    end
  end

  assign r_data1_o = regs[r_addr1_i];
  assign r_data2_o = regs[r_addr2_i];
  assign a0_o      = regs[10];

endmodule

`default_nettype wire

//--- hw/commit_monitor.sv
// commit and trap monitor
`default_nettype none

module commit_monitor import core_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  xlen_t      pc_i,
  input  inst_t      inst_i,
  input  logic       wen_i,
  input  logic [4:0] wdest_i,
  input  xlen_t      wdata_i,
  input  logic       is_trap_i,
  input  xlen_t      a0_i,
  output logic       halt_o,
  output commit_t    commit_o,
  output logic       trap_o,
  output logic [7:0] trap_code_o,
  output xlen_t      cycle_cnt_o,
  output xlen_t      instr_cnt_o
);

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_o    <= '0;
      trap_o      <= 1'b0;
      trap_code_o <= '0;
      cycle_cnt_o <= '0;
      instr_cnt_o <= '0;
    end else if (!trap_o) begin
      commit_o.valid <= 1'b1;
      commit_o.pc    <= pc_i;
      commit_o.inst  <= inst_i.word;
      commit_o.wen   <= wen_i;
      commit_o.wdest <= {3'b000, wdest_i};
      commit_o.wdata <= wdata_i;
      trap_o         <= is_trap_i;
      if (is_trap_i) begin
        trap_code_o <= a0_i[7:0];
      end
      cycle_cnt_o <= cycle_cnt_o + 64'd1;
      instr_cnt_o <= instr_cnt_o + 64'd1;
    end else begin
      // core frozen, nothing retires
      commit_o.valid <= 1'b0;
      commit_o.wen   <= 1'b0;
    end
  end

  assign halt_o = trap_o;

endmodule

`default_nettype wire

//--- hw/sim_top.sv
// single-cycle rv64i top
`default_nettype none

module sim_top import core_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 64
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          prog_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr_i,
  input  logic [31:0]                   prog_data_i,
  output commit_t                       commit_o,
  output logic                          trap_o,
  output logic [7:0]                    trap_code_o,
  output xlen_t                         cycle_cnt_o,
  output xlen_t                         instr_cnt_o
);

  xlen_t      pc;
  inst_t      inst;
  logic       halt;
  id_ex_t     id_ex;
  ex_out_t    ex_out;
  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      a0;
  logic       mem_ren;
  logic       mem_wen;
  xlen_t      mem_addr;
  xlen_t      mem_wdata;
  xlen_t      mem_rdata;
  logic       rd_wen;
  logic [4:0] rd_addr;
  xlen_t      rd_data;
  logic       is_trap;

  if_stage #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_if_stage (
    .clock        (clock),
    .reset        (reset),
    .halt_i       (halt),
    .pc_jmp_i     (ex_out.pc_jmp),
    .pc_jmpaddr_i (ex_out.pc_jmpaddr),
    .prog_we_i    (prog_we_i),
    .prog_addr_i  (prog_addr_i),
    .prog_data_i  (prog_data_i),
    .pc_o         (pc),
    .inst_o       (inst)
  );

  id_stage u_id_stage (
    .inst_i      (inst),
    .pc_i        (pc),
    .halt_i      (halt),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .mem_rdata_i (mem_rdata),
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .mem_ren_o   (mem_ren),
    .mem_wen_o   (mem_wen),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .ex_o        (id_ex),
    .ex_result_i (ex_out.result),
    .rd_wen_o    (rd_wen),
    .rd_addr_o   (rd_addr),
    .rd_data_o   (rd_data),
    .is_trap_o   (is_trap)
  );

  exe_stage u_exe_stage (
    .ex_i  (id_ex),
    .out_o (ex_out)
  );

  mem_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_mem_stage (
    .clock   (clock),
    .ren_i   (mem_ren),
    .wen_i   (mem_wen),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  regfile u_regfile (
    .clock     (clock),
    .reset     (reset),
    .w_ena_i   (rd_wen),
    .w_addr_i  (rd_addr),
    .w_data_i  (rd_data),
    .r_addr1_i (rs1_addr),
    .r_addr2_i (rs2_addr),
    .r_data1_o (rs1_data),
    .r_data2_o (rs2_data),
    .a0_o      (a0)
  );

  commit_monitor u_commit_monitor (
    .clock       (clock),
    .reset       (reset),
    .pc_i        (pc),
    .inst_i      (inst),
    .wen_i       (rd_wen),
    .wdest_i     (rd_addr),
    .wdata_i     (rd_data),
    .is_trap_i   (is_trap),
    .a0_i        (a0),
    .halt_o      (halt),
    .commit_o    (commit_o),
    .trap_o      (trap_o),
    .trap_code_o (trap_code_o),
    .cycle_cnt_o (cycle_cnt_o),
    .instr_cnt_o (instr_cnt_o)
  );

endmodule

`default_nettype wire

//--- test/sim_top_asserts.sv
// commit and trap assertions
`default_nettype none

module sim_top_asserts import core_pkg::*; (
  input logic    clock,
  input logic    reset,
  input commit_t commit_o,
  input logic    trap_o,
  input xlen_t   cycle_cnt_o,
  input xlen_t   instr_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // cleared during reset and on the first cycle after it
  reset_clears: assert property (@(posedge clock)
    reset |=> (!commit_o.valid && !commit_o.wen && !trap_o &&
               cycle_cnt_o == '0 && instr_cnt_o == '0))
    else begin
      $error("commit, trap or counter state not cleared by reset");
      fail_cnt++;
    end

  no_x0_write: assert property (@(posedge clock) disable iff (reset)
    commit_o.wen |-> commit_o.wdest != 8'd0)
    else begin
      $error("commit reports a write to x0");
      fail_cnt++;
    end

  // trap latches and the core stays frozen
  trap_freeze: assert property (@(posedge clock) disable iff (reset)
    trap_o |=> (trap_o && !commit_o.valid &&
                $stable(cycle_cnt_o) && $stable(instr_cnt_o)))
    else begin
      $error("core kept running after the trap");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- test/tb_sim_top.sv
// single-cycle core testbench
`default_nettype none

module tb_sim_top import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    PROG_LEN     = 13;
  localparam int    TRAP_TIMEOUT = 200;
  localparam xlen_t JAL_PC       = PC_START + 64'd40;
  localparam xlen_t SKIP_PC      = PC_START + 64'd44;

  logic        clock;
  logic        reset;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;
  commit_t     commit;
  logic        trap;
  logic [7:0]  trap_code;
  xlen_t       cycle_cnt;
  xlen_t       instr_cnt;

  logic [31:0] prog [PROG_LEN];
  logic [31:0] lcg_state;
  int          n_val;
  int          err_cnt = 0;
  int          timeout_cnt = 0;
  int          assert_cnt = 0;
  xlen_t       prev_pc;
  logic        have_prev;
  logic        prev_jump;

  sim_top #(
    .IMEM_DEPTH (256),
    .DMEM_DEPTH (64)
  ) DUT (
    .clock       (clock),
    .reset       (reset),
    .prog_we_i   (prog_we),
    .prog_addr_i (prog_addr),
    .prog_data_i (prog_data),
    .commit_o    (commit),
    .trap_o      (trap),
    .trap_code_o (trap_code),
    .cycle_cnt_o (cycle_cnt),
    .instr_cnt_o (instr_cnt)
  );

  bind sim_top sim_top_asserts u_asserts (
    .clock       (clock),
    .reset       (reset),
    .commit_o    (commit_o),
    .trap_o      (trap_o),
    .cycle_cnt_o (cycle_cnt_o),
    .instr_cnt_o (instr_cnt_o)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // sum loop, memory round trip, then jal over an a0 clear
  task automatic build_program(input int n);
    prog[0]  = itype_word(12'(n), 5'd0, 3'b000, 5'd1, OP_IMM);
    prog[1]  = itype_word(12'd0, 5'd0, 3'b000, 5'd2, OP_IMM);
    prog[2]  = rtype_word(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd2);
    prog[3]  = itype_word(12'hfff, 5'd1, 3'b000, 5'd1, OP_IMM);
    prog[4]  = btype_word(13'h1ff8, 5'd0, 5'd1, 3'b001);
    prog[5]  = stype_word(12'd8, 5'd2, 5'd0, 3'b011);
    prog[6]  = itype_word(12'd8, 5'd0, 3'b011, 5'd3, OP_LOAD);
    prog[7]  = rtype_word(7'b0100000, 5'd2, 5'd3, 3'b000, 5'd4);
    prog[8]  = rtype_word(7'b0000000, 5'd4, 5'd3, 3'b110, 5'd10);
    prog[9]  = rtype_word(7'b0000000, 5'd3, 5'd10, 3'b100, 5'd5);
    prog[10] = jtype_word(21'd8, 5'd7);
    prog[11] = itype_word(12'd0, 5'd0, 3'b000, 5'd10, OP_IMM);
    prog[12] = {25'd0, OP_TRAP};
  endtask

  // writes the image while reset is high, then releases reset
  task automatic load_program(input int len);
    for (int i = 0; i < len; i++) begin
      @(posedge clock);
      prog_we   <= 1'b1;
      prog_addr <= 8'(i);
      prog_data <= prog[i];
    end
    @(posedge clock);
    prog_we <= 1'b0;
    // core stays in reset for 10 cycles once the image is loaded
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  endtask

  task automatic wait_for_trap(output logic seen);
    int wait_cycles;
    wait_cycles = 0;
    while (!trap && wait_cycles < TRAP_TIMEOUT) begin
      @(negedge clock);
      wait_cycles++;
    end
    seen = trap;
    if (!trap) begin
      $display("Timeout: trap_o did not rise within %0d cycles", TRAP_TIMEOUT);
      timeout_cnt++;
    end
  endtask

  task automatic report_mismatch(input string test, input xlen_t exp, input xlen_t act);
    $display("Mismatch %s: expected 0x%0h, actual 0x%0h", test, exp, act);
    err_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    err_cnt++;
  endtask

  // commit stream scoreboard
  always @(negedge clock) begin
    if (reset) begin
      have_prev = 1'b0;
      prev_jump = 1'b0;
      prev_pc   = '0;
    end else if (commit.valid) begin
      if (!have_prev) begin
        assert (commit.pc == PC_START)
          else report_mismatch("first_pc", PC_START, commit.pc);
      end else if (!prev_jump) begin
        assert (commit.pc == prev_pc + 64'd4)
          else report_mismatch("seq_pc", prev_pc + 64'd4, commit.pc);
      end
      assert (commit.pc != SKIP_PC)
        else report_failure("the instruction after the jal was committed");
      if (commit.inst[6:0] == OP_JAL) begin
        assert (commit.pc == JAL_PC)
          else report_mismatch("jal_pc", JAL_PC, commit.pc);
        assert (commit.wen && commit.wdest == 8'd7 && commit.wdata == JAL_PC + 64'd4)
          else report_mismatch("jal_link", JAL_PC + 64'd4, commit.wdata);
      end
      prev_pc   = commit.pc;
      have_prev = 1'b1;
      prev_jump = (commit.inst[6:0] == OP_BRANCH) || (commit.inst[6:0] == OP_JAL);
    end
  end

  initial begin
    xlen_t sum_exp;
    logic  trapped;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lcg_state = lcg_next(32'd50062);
    n_val     = int'(lcg_state[30:16] % 15'd20) + 1;
    sum_exp   = 64'(n_val * (n_val + 1) / 2);
    build_program(n_val);
    load_program(PROG_LEN);
    wait_for_trap(trapped);
    if (trapped) begin
      assert (trap_code == sum_exp[7:0])
        else report_mismatch("trap_code", {56'd0, sum_exp[7:0]}, {56'd0, trap_code});
      assert (instr_cnt == 64'(3 * n_val + 9))
        else report_mismatch("instr_cnt", 64'(3 * n_val + 9), instr_cnt);
      // one instruction per clock, so cycles match retired instructions
      assert (cycle_cnt == 64'(3 * n_val + 9))
        else report_mismatch("cycle_cnt", 64'(3 * n_val + 9), cycle_cnt);
      // let the freeze assertions watch the halted core
      repeat (8) @(negedge clock);
      // second image: addi aimed at x0, then trap
      @(posedge clock);
      reset <= 1'b1;
      prog[0] = itype_word(12'd1, 5'd0, 3'b000, 5'd0, OP_IMM);
      prog[1] = {25'd0, OP_TRAP};
      load_program(2);
      wait_for_trap(trapped);
      if (trapped) begin
        assert (instr_cnt == 64'd2)
          else report_mismatch("x0_instr_cnt", 64'd2, instr_cnt);
      end
    end
    assert_cnt = int'(DUT.u_asserts.fail_cnt);
    $display("errors: mismatch %0d, timeout %0d, assertion %0d (N = %0d)",
             err_cnt, timeout_cnt, assert_cnt, n_val);
    if (err_cnt + timeout_cnt + assert_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hw/core_pkg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/exe_stage.sv
hw/mem_stage.sv
hw/regfile.sv
hw/commit_monitor.sv
hw/sim_top.sv
test/sim_top_asserts.sv
test/tb_sim_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sim_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
